//--- source/videopac_pkg.sv
/*
 * Shared widths, divider ratios, size thresholds and enums for the cartridge path.
 * Imported by every module of the console cartridge wrapper.
 */
`default_nettype none

package videopac_pkg;

	//////////////////////////////////////////////////
	// Bus and memory widths
	//////////////////////////////////////////////////

	// 16 KB cartridge ROM
	localparam int ROM_ADDR_W  = 14;
	localparam int DATA_W      = 8;
	// Console side sees a 4 KB window
	localparam int CART_ADDR_W = 12;
	// Byte counter for the image size
	localparam int SIZE_W      = 16;

	//////////////////////////////////////////////////
	// Clock enable periods in clk_sys cycles
	//////////////////////////////////////////////////

	localparam int DIV_W = 4;

	// CPU runs at sys/8 on NTSC, sys/12 on PAL
	localparam logic [DIV_W-1:0] NTSC_CPU_DIV = 4'd8;
	localparam logic [DIV_W-1:0] PAL_CPU_DIV  = 4'd12;
	// VDC runs at sys/6 on NTSC, sys/10 on PAL
	localparam logic [DIV_W-1:0] NTSC_VDC_DIV = 4'd6;
	localparam logic [DIV_W-1:0] PAL_VDC_DIV  = 4'd10;

	// Image sizes that switch to a banked layout
	localparam logic [SIZE_W-1:0] SIZE_4K  = 16'd4096;
	localparam logic [SIZE_W-1:0] SIZE_8K  = 16'd8192;
	localparam logic [SIZE_W-1:0] SIZE_16K = 16'd16384;

	//////////////////////////////////////////////////
	// Enums
	//////////////////////////////////////////////////

	// Download index from the host
	typedef enum logic [1:0] {
		slot_boot = 2'd0,
		slot_cart = 2'd1,
		slot_xrom = 2'd2,
		slot_font = 2'd3
	} download_slot_e;

	// Cartridge layout picked from the loaded image
	typedef enum logic [2:0] {
		kind_plain,
		kind_4k,
		kind_8k,
		kind_16k,
		kind_xrom
	} cart_kind_e;

endpackage

`default_nettype wire

//--- source/console_clock_enables.sv
/*
 * CPU and VDC clock enable pulses derived from clk_sys.
 * Ratios follow pal_i; a change of standard restarts both dividers.
 */
`timescale 1ns/1ps
`default_nettype none

module console_clock_enables (
	input  logic clk_sys,
	input  logic reset,
	input  logic pal_i,
	output logic clk_cpu_en_o,
	output logic clk_vdc_en_o
);

	import videopac_pkg::*;

	// Divider counters
	logic [DIV_W-1:0] cpu_cnt;
	logic [DIV_W-1:0] vdc_cnt;
	// Last count before wrap, per standard
	logic [DIV_W-1:0] cpu_last;
	logic [DIV_W-1:0] vdc_last;
	// Previous standard, for change detect
	logic             pal_q;
	logic             pal_change;

	always_comb begin
		cpu_last = pal_i ? PAL_CPU_DIV - 4'd1 : NTSC_CPU_DIV - 4'd1;
		vdc_last = pal_i ? PAL_VDC_DIV - 4'd1 : NTSC_VDC_DIV - 4'd1;
	end

	assign pal_change = pal_i != pal_q;

	//////////////////////////////////////////////////
	// Dividers
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			pal_q        <= 1'b0;
			cpu_cnt      <= '0;
			vdc_cnt      <= '0;
			clk_cpu_en_o <= 1'b0;
			clk_vdc_en_o <= 1'b0;
		end else begin
			pal_q <= pal_i;
			if (pal_change) begin
				// New standard, full period before the next pulse
				cpu_cnt      <= '0;
				vdc_cnt      <= '0;
				clk_cpu_en_o <= 1'b0;
				clk_vdc_en_o <= 1'b0;
			end else begin
				// CPU divider
				if (cpu_cnt >= cpu_last) begin
					cpu_cnt      <= '0;
					clk_cpu_en_o <= 1'b1;
				end else begin
					cpu_cnt      <= cpu_cnt + 4'd1;
					clk_cpu_en_o <= 1'b0;
				end
				// VDC divider
				if (vdc_cnt >= vdc_last) begin
					vdc_cnt      <= '0;
					clk_vdc_en_o <= 1'b1;
				end else begin
					vdc_cnt      <= vdc_cnt + 4'd1;
					clk_vdc_en_o <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- source/cart_loader.sv
/*
 * Download tracker that steers image bytes into the cartridge ROM,
 * counts the stored bytes and classifies the layout for the bus mapper.
 */
`timescale 1ns/1ps
`default_nettype none

module cart_loader (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  logic                            download_i,
	input  logic                            download_wr_i,
	input  videopac_pkg::download_slot_e    download_index_i,
	input  logic [videopac_pkg::ROM_ADDR_W-1:0] download_addr_i,
	input  logic [videopac_pkg::DATA_W-1:0] download_data_i,
	output logic                            rom_we_o,
	output logic [videopac_pkg::ROM_ADDR_W-1:0] rom_waddr_o,
	output logic [videopac_pkg::DATA_W-1:0] rom_wdata_o,
	output videopac_pkg::cart_kind_e        cart_kind_o,
	output logic                            busy_o
);

	import videopac_pkg::*;

	logic              download_q;
	logic              start;
	logic              slot_ok;
	logic              store;
	logic [SIZE_W-1:0] size_cnt;
	logic              xrom_q;

	//////////////////////////////////////////////////
	// Write filter
	//////////////////////////////////////////////////

	// Rising edge of the download level
	assign start   = download_i & ~download_q;
	// Font slot has no target here
	assign slot_ok = download_index_i != slot_font;
	// Start cycle only clears, nothing stored
	assign store   = download_i & download_wr_i & slot_ok & ~start;

	// Straight to the ROM write port, same cycle
	assign rom_we_o    = store;
	assign rom_waddr_o = download_addr_i;
	assign rom_wdata_o = download_data_i;

	// Busy level for the LED
	assign busy_o = download_q;

	//////////////////////////////////////////////////
	// Size count and XROM flag
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			download_q <= 1'b0;
			size_cnt   <= '0;
			xrom_q     <= 1'b0;
		end else begin
			download_q <= download_i;
			if (start) begin
				size_cnt <= '0;
				xrom_q   <= download_index_i == slot_xrom;
			end else if (store) begin
				size_cnt <= size_cnt + 16'd1;
			end
		end
	end

	// Layout from flag and exact byte count
	always_comb begin
		if (xrom_q) begin
			cart_kind_o = kind_xrom;
		end else begin
			case (size_cnt)
				SIZE_4K:  cart_kind_o = kind_4k;
				SIZE_8K:  cart_kind_o = kind_8k;
				SIZE_16K: cart_kind_o = kind_16k;
				default:  cart_kind_o = kind_plain;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/cart_rom.sv
/*
 * 16 K x 8 cartridge memory, one write port and one registered read port.
 * Read data only updates on cycles with re_i high.
 */
`timescale 1ns/1ps
`default_nettype none

module cart_rom (
	input  logic                                clk_sys,
	input  logic                                we_i,
	input  logic [videopac_pkg::ROM_ADDR_W-1:0] waddr_i,
	input  logic [videopac_pkg::DATA_W-1:0]     wdata_i,
	input  logic                                re_i,
	input  logic [videopac_pkg::ROM_ADDR_W-1:0] raddr_i,
	output logic [videopac_pkg::DATA_W-1:0]     rdata_o
);

	import videopac_pkg::*;

	// Block RAM
	logic [DATA_W-1:0] mem [2**ROM_ADDR_W];

	//////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (we_i) begin
			mem[waddr_i] <= wdata_i;
		end
	end

	//////////////////////////////////////////////////
	// Read port
	//////////////////////////////////////////////////

	// One cycle latency, output holds while re_i is low
	always_ff @(posedge clk_sys) begin
		if (re_i) begin
			rdata_o <= mem[raddr_i];
		end
	end

endmodule

`default_nettype wire

//--- source/cart_bus_mapper.sv
/*
 * Maps the console cartridge bus onto the ROM address and read enable.
 * Layout depends on the cartridge kind reported by the loader.
 */
`timescale 1ns/1ps
`default_nettype none

module cart_bus_mapper (
	input  videopac_pkg::cart_kind_e             cart_kind_i,
	input  logic [videopac_pkg::CART_ADDR_W-1:0] cart_addr_i,
	input  logic                                 cart_bs0_i,
	input  logic                                 cart_bs1_i,
	input  logic                                 cart_psen_n_i,
	input  logic                                 cart_cs_n_i,
	output logic [videopac_pkg::ROM_ADDR_W-1:0]  rom_raddr_o,
	output logic                                 rom_re_o
);

	import videopac_pkg::*;

	// Low 1 KB of the window, shared by the banked layouts
	logic [9:0]             addr_lo;
	// A11 selects the upper 2 KB half
	logic                   addr_hi;
	// Full 4 KB window
	logic [CART_ADDR_W-1:0] addr_full;
	// XROM read qualifier
	logic                   xrom_re;

	assign addr_lo   = cart_addr_i[9:0];
	assign addr_hi   = cart_addr_i[11];
	assign addr_full = cart_addr_i;

	//////////////////////////////////////////////////
	// Address layouts
	//////////////////////////////////////////////////

	// A10 is skipped except in the 12-bit layouts
	always_comb begin
		case (cart_kind_i)
			kind_4k: begin
				// One bank line, two 2 KB banks
				rom_raddr_o = ROM_ADDR_W'({cart_bs0_i, addr_hi, addr_lo});
			end
			kind_8k: begin
				// Four 2 KB banks
				rom_raddr_o = ROM_ADDR_W'({cart_bs1_i, cart_bs0_i, addr_hi, addr_lo});
			end
			kind_16k: begin
				// Four 4 KB banks, A10 in use
				rom_raddr_o = {cart_bs1_i, cart_bs0_i, addr_full};
			end
			kind_xrom: begin
				// Linear, no banking
				rom_raddr_o = ROM_ADDR_W'(addr_full);
			end
			default: begin
				// Plain 2 KB image
				rom_raddr_o = ROM_ADDR_W'({addr_hi, addr_lo});
			end
		endcase
	end

	//////////////////////////////////////////////////
	// Read enable
	//////////////////////////////////////////////////

	// XROM answers data reads, but not when cs_n and bs0 are both high
	assign xrom_re = cart_psen_n_i & ~(cart_cs_n_i & cart_bs0_i);

	// Program fetch with psen_n low for all other kinds
	always_comb begin
		if (cart_kind_i == kind_xrom) begin
			rom_re_o = xrom_re;
		end else begin
			rom_re_o = ~cart_psen_n_i;
		end
	end

endmodule

`default_nettype wire

//--- source/videopac_cart_top.sv
/*
 * Cartridge side of the console wrapper with its clock enables.
 * Loader writes the ROM, the bus mapper reads it for the console.
 */
`timescale 1ns/1ps
`default_nettype none

module videopac_cart_top (
	input  logic                                 clk_sys,
	input  logic                                 reset,
	input  logic                                 pal_i,
	// Host download
	input  logic                                 download_i,
	input  logic                                 download_wr_i,
	input  videopac_pkg::download_slot_e         download_index_i,
	input  logic [videopac_pkg::ROM_ADDR_W-1:0]  download_addr_i,
	input  logic [videopac_pkg::DATA_W-1:0]      download_data_i,
	// Console cartridge bus
	input  logic [videopac_pkg::CART_ADDR_W-1:0] cart_addr_i,
	input  logic                                 cart_bs0_i,
	input  logic                                 cart_bs1_i,
	input  logic                                 cart_psen_n_i,
	input  logic                                 cart_cs_n_i,
	output logic [videopac_pkg::DATA_W-1:0]      cart_d_o,
	// Enables and status
	output logic                                 clk_cpu_en_o,
	output logic                                 clk_vdc_en_o,
	output logic                                 busy_o
);

	import videopac_pkg::*;

	// Loader to ROM
	logic                  rom_we;
	logic [ROM_ADDR_W-1:0] rom_waddr;
	logic [DATA_W-1:0]     rom_wdata;
	// Mapper to ROM
	logic [ROM_ADDR_W-1:0] rom_raddr;
	logic                  rom_re;
	// Loader to mapper
	cart_kind_e            cart_kind;

	//////////////////////////////////////////////////
	// Clock enables
	//////////////////////////////////////////////////

	console_clock_enables u_clock_enables (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.pal_i        (pal_i),
		.clk_cpu_en_o (clk_cpu_en_o),
		.clk_vdc_en_o (clk_vdc_en_o)
	);

	//////////////////////////////////////////////////
	// Cartridge path
	//////////////////////////////////////////////////

	cart_loader u_loader (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.download_i       (download_i),
		.download_wr_i    (download_wr_i),
		.download_index_i (download_index_i),
		.download_addr_i  (download_addr_i),
		.download_data_i  (download_data_i),
		.rom_we_o         (rom_we),
		.rom_waddr_o      (rom_waddr),
		.rom_wdata_o      (rom_wdata),
		.cart_kind_o      (cart_kind),
		.busy_o           (busy_o)
	);

	cart_rom u_rom (
		.clk_sys (clk_sys),
		.we_i    (rom_we),
		.waddr_i (rom_waddr),
		.wdata_i (rom_wdata),
		.re_i    (rom_re),
		.raddr_i (rom_raddr),
		.rdata_o (cart_d_o)
	);

	// Pure decode, the ROM registers the result
	cart_bus_mapper u_mapper (
		.cart_kind_i   (cart_kind),
		.cart_addr_i   (cart_addr_i),
		.cart_bs0_i    (cart_bs0_i),
		.cart_bs1_i    (cart_bs1_i),
		.cart_psen_n_i (cart_psen_n_i),
		.cart_cs_n_i   (cart_cs_n_i),
		.rom_raddr_o   (rom_raddr),
		.rom_re_o      (rom_re)
	);

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
/*
 * Testbench clock and reset source.
 * Reset stays high for a fixed number of rising edges, then drops just after one.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS    = 100,
	parameter int RESET_CYCLES = 3,
	parameter int RELEASE_NS   = 1
) (
	output logic clk_sys_o,
	output logic reset_o
);

	// Free running clock
	initial begin
		clk_sys_o = 1'b0;
		forever #(PERIOD_NS / 2) clk_sys_o = ~clk_sys_o;
	end

	// Release shortly after the last reset edge
	initial begin
		reset_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys_o);
		#(RELEASE_NS) reset_o = 1'b0;
	end

endmodule

`default_nettype wire

//--- bench/tb_videopac_cart.sv
/*
 * Testbench for the cartridge wrapper covering enable spacing, downloads, bank layouts and XROM.
 * Image bytes are random, mirrored in a model array; assertions compare the DUT with it.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_videopac_cart;

	import videopac_pkg::*;

	localparam int CLK_PERIOD   = 100;
	localparam int DRIVE_DLY    = 10;
	localparam int SEED         = 32'h4ae3;
	// Test lengths in cycles or reads
	localparam int NTSC_CYCLES  = 80;
	localparam int PAL_CYCLES   = 90;
	localparam int LOAD_BYTES   = 2048 + 4096 + 4096 + 8192 + 16384 + 4096;
	localparam int LOAD_STEPS   = 6 * 5;
	localparam int BANK_READS   = 64;
	localparam int PLAIN_ITERS  = 32;
	localparam int FONT_READS   = 32;
	localparam int XROM_READS   = 128;
	localparam int READ_STEPS   = 3 * PLAIN_ITERS + FONT_READS + 3 * BANK_READS + XROM_READS;
	localparam int TOTAL_CYCLES = 2 * NTSC_CYCLES + PAL_CYCLES + LOAD_BYTES + LOAD_STEPS
		+ READ_STEPS;
	localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 1000) * CLK_PERIOD;
	// Expected enable spacing
	localparam int unsigned CPU_GAP_NTSC = 8;
	localparam int unsigned CPU_GAP_PAL  = 12;
	localparam int unsigned VDC_GAP_NTSC = 6;
	localparam int unsigned VDC_GAP_PAL  = 10;

	logic                   clk_sys;
	logic                   reset;
	logic                   pal_i;
	logic                   download_i;
	logic                   download_wr_i;
	download_slot_e         download_index_i;
	logic [ROM_ADDR_W-1:0]  download_addr_i;
	logic [DATA_W-1:0]      download_data_i;
	logic [CART_ADDR_W-1:0] cart_addr_i;
	logic                   cart_bs0_i;
	logic                   cart_bs1_i;
	logic                   cart_psen_n_i;
	logic                   cart_cs_n_i;
	logic [DATA_W-1:0]      cart_d_o;
	logic                   clk_cpu_en_o;
	logic                   clk_vdc_en_o;
	logic                   busy_o;

	// Reference state
	logic [DATA_W-1:0] model_rom [2**ROM_ADDR_W];
	logic [DATA_W-1:0] held_data = 'x;
	cart_kind_e        exp_kind  = kind_plain;
	logic              download_q;
	integer            seed      = SEED;

	// Error and event counters
	int unsigned enable_errors = 0;
	int unsigned reset_errors  = 0;
	int unsigned busy_errors   = 0;
	int unsigned main_errors   = 0;
	int unsigned cpu_pulses    = 0;
	int unsigned vdc_pulses    = 0;
	int unsigned read_count    = 0;

	tb_clock #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(3)) u_clock (
		.clk_sys_o (clk_sys),
		.reset_o   (reset)
	);

	videopac_cart_top dut (
		.clk_sys          (clk_sys),
		.reset            (reset),
		.pal_i            (pal_i),
		.download_i       (download_i),
		.download_wr_i    (download_wr_i),
		.download_index_i (download_index_i),
		.download_addr_i  (download_addr_i),
		.download_data_i  (download_data_i),
		.cart_addr_i      (cart_addr_i),
		.cart_bs0_i       (cart_bs0_i),
		.cart_bs1_i       (cart_bs1_i),
		.cart_psen_n_i    (cart_psen_n_i),
		.cart_cs_n_i      (cart_cs_n_i),
		.cart_d_o         (cart_d_o),
		.clk_cpu_en_o     (clk_cpu_en_o),
		.clk_vdc_en_o     (clk_vdc_en_o),
		.busy_o           (busy_o)
	);

	//////////////////////////////////////////////////
	// Reference rules
	//////////////////////////////////////////////////

	// ROM address per layout table, zero fill above
	function automatic logic [ROM_ADDR_W-1:0] expected_rom_addr(input cart_kind_e kind,
		input logic [11:0] a, input logic bs0, input logic bs1);
		logic [ROM_ADDR_W-1:0] r;
		case (kind)
			kind_plain: r = {3'b000, a[11], a[9:0]};
			kind_4k:    r = {2'b00, bs0, a[11], a[9:0]};
			kind_8k:    r = {1'b0, bs1, bs0, a[11], a[9:0]};
			kind_16k:   r = {bs1, bs0, a};
			kind_xrom:  r = {2'b00, a};
			default:    r = '0;
		endcase
		return r;
	endfunction

	// XROM reads on data strobes unless cs_n and bs0 are both high
	function automatic logic expected_read_enable(input cart_kind_e kind, input logic psen_n,
		input logic cs_n, input logic bs0);
		if (kind == kind_xrom) begin
			return psen_n && !(cs_n && bs0);
		end
		return !psen_n;
	endfunction

	function automatic cart_kind_e expected_kind(input logic xrom, input int unsigned count);
		if (xrom) begin
			return kind_xrom;
		end
		if (count == 4096) begin
			return kind_4k;
		end
		if (count == 8192) begin
			return kind_8k;
		end
		if (count == 16384) begin
			return kind_16k;
		end
		return kind_plain;
	endfunction

	//////////////////////////////////////////////////
	// Concurrent checks
	//////////////////////////////////////////////////

	always @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			download_q <= 1'b0;
		end else begin
			download_q <= download_i;
		end
	end

	assert property (@(posedge clk_sys) reset |-> !clk_cpu_en_o && !clk_vdc_en_o && !busy_o)
		else begin
			reset_errors = reset_errors + 1;
			$display("FAIL reset outputs: clk_cpu_en_o %h clk_vdc_en_o %h busy_o %h expected 0",
				$sampled(clk_cpu_en_o), $sampled(clk_vdc_en_o), $sampled(busy_o));
		end

	// Busy is the download level one cycle late
	assert property (@(posedge clk_sys) disable iff (reset) busy_o == download_q)
		else begin
			busy_errors = busy_errors + 1;
			$display("FAIL busy_o: got %h expected %h", $sampled(busy_o), $sampled(download_q));
		end

	//////////////////////////////////////////////////
	// Enable spacing monitor
	//////////////////////////////////////////////////

	// Reference edge is the last clear or the last pulse, in edge numbers
	always @(posedge clk_sys) begin : enable_monitor
		int unsigned edge_n;
		int unsigned cpu_ref;
		int unsigned vdc_ref;
		int unsigned cpu_gap;
		int unsigned vdc_gap;
		int unsigned cpu_period;
		int unsigned vdc_period;
		logic        pal_prev;
		edge_n = edge_n + 1;
		if (reset) begin
			cpu_ref  = edge_n;
			vdc_ref  = edge_n;
			pal_prev = 1'b0;
		end else begin
			cpu_period = pal_prev ? CPU_GAP_PAL : CPU_GAP_NTSC;
			vdc_period = pal_prev ? VDC_GAP_PAL : VDC_GAP_NTSC;
			// A pulse seen now was set on the previous edge
			cpu_gap = edge_n - 1 - cpu_ref;
			vdc_gap = edge_n - 1 - vdc_ref;
			if (clk_cpu_en_o) begin
				assert (cpu_gap == cpu_period) else begin
					enable_errors = enable_errors + 1;
					$display("FAIL clk_cpu_en_o spacing: got %h expected %h", cpu_gap, cpu_period);
				end
				cpu_ref    = edge_n - 1;
				cpu_pulses = cpu_pulses + 1;
			end else begin
				assert (cpu_gap < cpu_period) else begin
					enable_errors = enable_errors + 1;
					$display("CPU enable pulse missing, %0d cycles since the last one", cpu_gap);
				end
			end
			if (clk_vdc_en_o) begin
				assert (vdc_gap == vdc_period) else begin
					enable_errors = enable_errors + 1;
					$display("FAIL clk_vdc_en_o spacing: got %h expected %h", vdc_gap, vdc_period);
				end
				vdc_ref    = edge_n - 1;
				vdc_pulses = vdc_pulses + 1;
			end else begin
				assert (vdc_gap < vdc_period) else begin
					enable_errors = enable_errors + 1;
					$display("VDC enable pulse missing, %0d cycles since the last one", vdc_gap);
				end
			end
			// Standard change restarts both dividers on this edge
			if (pal_i != pal_prev) begin
				cpu_ref = edge_n;
				vdc_ref = edge_n;
			end
			pal_prev = pal_i;
		end
	end

	//////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////

	task automatic step();
		@(posedge clk_sys);
		#(DRIVE_DLY);
	endtask

	// Quiet bus, no read for any kind
	task automatic bus_idle();
		cart_addr_i   = '0;
		cart_bs0_i    = 1'b1;
		cart_bs1_i    = 1'b0;
		cart_psen_n_i = 1'b1;
		cart_cs_n_i   = 1'b1;
	endtask

	// Start cycle without a write, then one byte per cycle
	task automatic load_image(input download_slot_e slot, input int unsigned nbytes);
		int unsigned i;
		int unsigned stored;
		logic [31:0] rnd;
		download_i       = 1'b1;
		download_index_i = slot;
		download_wr_i    = 1'b0;
		stored           = 0;
		step();
		for (i = 0; i < nbytes; i++) begin
			rnd             = $random(seed);
			download_wr_i   = 1'b1;
			download_addr_i = i[ROM_ADDR_W-1:0];
			download_data_i = rnd[7:0];
			if (slot != slot_font) begin
				model_rom[i[ROM_ADDR_W-1:0]] = rnd[7:0];
				stored = stored + 1;
			end
			step();
		end
		download_wr_i = 1'b0;
		step();
		download_i = 1'b0;
		step();
		step();
		exp_kind = expected_kind(slot == slot_xrom, stored);
	endtask

	// Drive one bus cycle, check the registered byte a cycle later
	task automatic bus_read(input logic [11:0] addr, input logic bs0, input logic bs1,
		input logic psen_n, input logic cs_n);
		cart_addr_i   = addr;
		cart_bs0_i    = bs0;
		cart_bs1_i    = bs1;
		cart_psen_n_i = psen_n;
		cart_cs_n_i   = cs_n;
		step();
		if (expected_read_enable(exp_kind, psen_n, cs_n, bs0)) begin
			held_data = model_rom[expected_rom_addr(exp_kind, addr, bs0, bs1)];
		end
		assert (cart_d_o === held_data) else begin
			main_errors = main_errors + 1;
			$display("FAIL cart_d_o: got %h expected %h (addr %h bs1 %h bs0 %h psen_n %h cs_n %h)",
				cart_d_o, held_data, addr, bs1, bs0, psen_n, cs_n);
		end
		read_count = read_count + 1;
	endtask

	task automatic random_reads(input int unsigned count, input logic vary_strobes);
		int unsigned n;
		int unsigned enabled;
		logic [31:0] rnd;
		logic        psen_n;
		enabled = 0;
		for (n = 0; n < count; n++) begin
			rnd    = $random(seed);
			psen_n = vary_strobes ? rnd[14] : 1'b0;
			if (expected_read_enable(exp_kind, psen_n, rnd[15], rnd[12])) begin
				enabled = enabled + 1;
			end
			bus_read(rnd[11:0], rnd[12], rnd[13], psen_n, rnd[15]);
		end
		// Random strobes must hit both read and hold cycles
		if (vary_strobes) begin
			assert (enabled > 0 && enabled < count) else begin
				main_errors = main_errors + 1;
				$display("Random reads did not reach both enabled and held cycles");
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin : stimulus
		int unsigned i;
		int unsigned cpu_start;
		int unsigned vdc_start;
		int unsigned total;
		logic [31:0] rnd;
		logic [11:0] addr;
		pal_i            = 1'b0;
		download_i       = 1'b0;
		download_wr_i    = 1'b0;
		download_index_i = slot_boot;
		download_addr_i  = '0;
		download_data_i  = '0;
		bus_idle();
		wait (reset === 1'b0);
		step();

		// Enables on NTSC, PAL, then NTSC again
		cpu_start = cpu_pulses;
		vdc_start = vdc_pulses;
		repeat (NTSC_CYCLES) step();
		assert (cpu_pulses > cpu_start && vdc_pulses > vdc_start) else begin
			main_errors = main_errors + 1;
			$display("No enable pulses seen with pal_i low");
		end
		pal_i     = 1'b1;
		cpu_start = cpu_pulses;
		vdc_start = vdc_pulses;
		repeat (PAL_CYCLES) step();
		assert (cpu_pulses > cpu_start && vdc_pulses > vdc_start) else begin
			main_errors = main_errors + 1;
			$display("No enable pulses seen with pal_i high");
		end
		pal_i = 1'b0;
		repeat (NTSC_CYCLES) step();

		// Plain 2 KB image, A10 pairs plus hold cycles
		load_image(slot_cart, 2048);
		for (i = 0; i < PLAIN_ITERS; i++) begin
			rnd  = $random(seed);
			addr = rnd[11:0];
			bus_read(addr, rnd[12], rnd[13], 1'b0, rnd[15]);
			bus_read(addr ^ 12'h400, rnd[12], rnd[13], 1'b0, rnd[15]);
			bus_read(~addr, rnd[12], rnd[13], 1'b1, rnd[15]);
		end
		bus_idle();

		// Font download of a 4 KB size, image and plain layout stay
		load_image(slot_font, 4096);
		for (i = 0; i < FONT_READS; i++) begin
			rnd = $random(seed);
			bus_read(rnd[11:0], rnd[12], rnd[13], 1'b0, rnd[15]);
		end
		bus_idle();

		// Banked layouts
		load_image(slot_cart, 4096);
		random_reads(BANK_READS, 1'b0);
		bus_idle();
		load_image(slot_cart, 8192);
		random_reads(BANK_READS, 1'b0);
		bus_idle();
		load_image(slot_cart, 16384);
		random_reads(BANK_READS, 1'b0);
		bus_idle();

		// XROM with random strobes
		load_image(slot_xrom, 4096);
		random_reads(XROM_READS, 1'b1);
		bus_idle();
		step();

		total = enable_errors + reset_errors + busy_errors + main_errors;
		$display("Summary: %0d reads, %0d errors (enables %0d, reset %0d, busy %0d, data %0d)",
			read_count, total, enable_errors, reset_errors, busy_errors, main_errors);
		if (total == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	// Run limit from the summed test lengths
	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, the test sequence did not complete", WATCHDOG_NS);
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
source/videopac_pkg.sv
source/console_clock_enables.sv
source/cart_loader.sv
source/cart_rom.sv
source/cart_bus_mapper.sv
source/videopac_cart_top.sv
bench/tb_clock.sv
bench/tb_videopac_cart.sv

//--- Makefile
# Verilator build, run, lint and clean for the cartridge wrapper testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
TOP       := tb_videopac_cart
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
PASS_MSG  := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The pass line must appear on a line of its own in the simulator output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
